/* awp_macros.svh */
// width and stage count definitions for the normalizing unit
// plus the APB register byte addresses
`ifndef AWP_MACROS_SVH
`define AWP_MACROS_SVH

// datapath widths
`define AWP_MANT_W 32
`define AWP_EXP_W 8
// working exponent, wide enough that no range error can wrap
`define AWP_WEXP_W 10

// stage i shifts by 2**(stages-1-i)
`define AWP_NORM_STAGES 5

// APB side
`define AWP_ADDR_W 5
`define AWP_DATA_W 32

// register byte addresses
`define AWP_REG_MANT_A 5'h00
`define AWP_REG_MANT_B 5'h04
`define AWP_REG_EXP_A 5'h08
`define AWP_REG_EXP_B 5'h0C
`define AWP_REG_CMD 5'h10
`define AWP_REG_STATUS 5'h14
`define AWP_REG_RES_MANT 5'h18
`define AWP_REG_RES_EXP 5'h1C

`endif

/* awp_pkg.sv */
// shared types of the normalizing unit
// operands, command, job, flags, result and sequencer states
`default_nettype none
`include "awp_macros.svh"

package awp_pkg;

	// ----------------------------------------------------------------------
	// plain vectors
	typedef logic signed [`AWP_MANT_W-1:0] awp_mant_t;
	typedef logic signed [`AWP_EXP_W-1:0] awp_exp_t;
	typedef logic signed [`AWP_WEXP_W-1:0] awp_wexp_t;

	// command code, bit 0 of the CMD write
	typedef enum logic {
		NRF = 1'b0,
		AD = 1'b1
	} awp_op_e;

	// ----------------------------------------------------------------------
	// bundles
	typedef struct packed {
		awp_op_e op;
		awp_mant_t mant_a;
		awp_mant_t mant_b;
		awp_exp_t exp_a;
		awp_exp_t exp_b;
	} awp_cmd_t;

	// one job in flight through the stage chain
	typedef struct packed {
		logic valid;
		awp_mant_t mant;
		awp_wexp_t wexp;
	} awp_job_t;

	typedef struct packed {
		logic zero;
		logic underflow;
		logic overflow;
	} awp_flags_t;

	typedef struct packed {
		awp_mant_t mant;
		awp_exp_t exp;
		awp_flags_t flags;
	} awp_res_t;

	typedef enum logic [2:0] {
		IDLE,
		ALIGN,
		ADD,
		ISSUE,
		WAIT
	} awp_seq_state_e;

endpackage

`default_nettype wire

/* awp_apb_regs.sv */
// APB slave register file: operands, command launch, result latch,
// status bits and the completion interrupt
`timescale 1ns/1ns
`default_nettype none
`include "awp_macros.svh"

module awp_apb_regs (
	input  logic                   got_fp,
	input  logic                   _0_f,
	input  logic [`AWP_ADDR_W-1:0] paddr,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic [`AWP_DATA_W-1:0] pwdata,
	output logic [`AWP_DATA_W-1:0] prdata,
	output logic                   pready,
	output logic                   pslverr,
	input  logic                   busy,
	input  awp_pkg::awp_res_t      result,
	input  logic                   done,
	output awp_pkg::awp_cmd_t      cmd,
	output logic                   start,
	output logic                   irq
);

	localparam int EXP_PAD = `AWP_DATA_W - `AWP_EXP_W;

	awp_pkg::awp_mant_t mant_a_q;
	awp_pkg::awp_mant_t mant_b_q;
	awp_pkg::awp_exp_t exp_a_q;
	awp_pkg::awp_exp_t exp_b_q;
	awp_pkg::awp_res_t res_q;
	logic done_q;
	logic access;
	logic bad_addr;
	logic ro_write;
	logic busy_cmd;
	logic wr_ok;
	logic rd_status;

	// ----------------------------------------------------------------------
	// decode, no wait states
	assign pready = 1'b1;
	assign access = psel & penable;
	assign bad_addr = paddr > `AWP_REG_RES_EXP;
	assign ro_write = pwrite & ((paddr == `AWP_REG_STATUS) | (paddr == `AWP_REG_RES_MANT) |
		(paddr == `AWP_REG_RES_EXP));
	assign busy_cmd = pwrite & (paddr == `AWP_REG_CMD) & busy;
	assign pslverr = access & (bad_addr | ro_write | busy_cmd);
	assign wr_ok = access & pwrite & ~pslverr;
	assign start = wr_ok & (paddr == `AWP_REG_CMD);
	assign rd_status = access & ~pwrite & (paddr == `AWP_REG_STATUS);

	// operand registers
	always_ff @(posedge got_fp) begin
		if (wr_ok) begin
			case (paddr)
				`AWP_REG_MANT_A: mant_a_q <= pwdata;
				`AWP_REG_MANT_B: mant_b_q <= pwdata;
				`AWP_REG_EXP_A: exp_a_q <= pwdata[`AWP_EXP_W-1:0];
				`AWP_REG_EXP_B: exp_b_q <= pwdata[`AWP_EXP_W-1:0];
				default: ;
			endcase
		end
	end

	// op comes straight from the CMD write data
	always_comb begin
		cmd.op = pwdata[0] ? awp_pkg::AD : awp_pkg::NRF;
		cmd.mant_a = mant_a_q;
		cmd.mant_b = mant_b_q;
		cmd.exp_a = exp_a_q;
		cmd.exp_b = exp_b_q;
	end

	// ----------------------------------------------------------------------
	// result latch, done and irq
	always_ff @(posedge got_fp or posedge _0_f) begin
		if (_0_f) begin
			res_q <= '0;
			done_q <= 1'b0;
			irq <= 1'b0;
		end else begin
			if (done)
				res_q <= result;
			if (done)
				done_q <= 1'b1;
			else if (start)
				done_q <= 1'b0;
			// set wins over a STATUS read in the same cycle
			if (done)
				irq <= 1'b1;
			else if (start | rd_status)
				irq <= 1'b0;
		end
	end

	always_comb begin
		prdata = '0;
		if (psel & ~pwrite) begin
			case (paddr)
				`AWP_REG_MANT_A: prdata = mant_a_q;
				`AWP_REG_MANT_B: prdata = mant_b_q;
				`AWP_REG_EXP_A: prdata = {{EXP_PAD{1'b0}}, exp_a_q};
				`AWP_REG_EXP_B: prdata = {{EXP_PAD{1'b0}}, exp_b_q};
				`AWP_REG_STATUS: prdata = {25'd0, res_q.flags.overflow,
					res_q.flags.underflow, res_q.flags.zero, 2'b00, done_q, busy};
				`AWP_REG_RES_MANT: prdata = res_q.mant;
				`AWP_REG_RES_EXP: prdata = {{EXP_PAD{1'b0}}, res_q.exp};
				default: prdata = '0;
			endcase
		end
	end

	// an accepted command always finds the sequencer idle and makes it busy
	a_no_start_busy: assert property (@(posedge got_fp) disable iff (_0_f)
		busy |-> !start);
	a_start_busy: assert property (@(posedge got_fp) disable iff (_0_f)
		start |=> busy);

endmodule

`default_nettype wire

/* awp_seq.sv */
// control sequencer: exponent compare, alignment shift, widened add
// with overflow correction, job issue to the stage chain
`timescale 1ns/1ns
`default_nettype none
`include "awp_macros.svh"

module awp_seq (
	input  logic              got_fp,
	input  logic              _0_f,
	input  awp_pkg::awp_cmd_t cmd,
	input  logic              start,
	input  logic              done,
	output awp_pkg::awp_job_t job,
	output logic              busy
);

	localparam int SH_W = $clog2(`AWP_MANT_W);
	localparam int SH_MAX = `AWP_MANT_W - 1;
	localparam int EXT_W = `AWP_WEXP_W - `AWP_EXP_W;

	awp_pkg::awp_seq_state_e state;
	awp_pkg::awp_mant_t a_q;
	awp_pkg::awp_mant_t b_q;
	awp_pkg::awp_mant_t res_mant_q;
	awp_pkg::awp_exp_t ea_q;
	awp_pkg::awp_exp_t eb_q;
	awp_pkg::awp_wexp_t res_wexp_q;
	awp_pkg::awp_wexp_t ea_ext;
	logic job_valid_q;

	logic [`AWP_EXP_W:0] diff;
	logic [`AWP_EXP_W:0] diff_mag;
	logic [SH_W-1:0] sh_amt;
	logic a_smaller;
	logic [`AWP_MANT_W:0] sum;
	logic sum_ovf;

	// ----------------------------------------------------------------------
	// align and add datapath
	always_comb begin
		diff = {ea_q[`AWP_EXP_W-1], ea_q} - {eb_q[`AWP_EXP_W-1], eb_q};
		a_smaller = diff[`AWP_EXP_W];
		diff_mag = a_smaller ? -diff : diff;
		// beyond 31 only sign bits remain
		if (diff_mag > SH_MAX)
			sh_amt = SH_W'(SH_MAX);
		else
			sh_amt = diff_mag[SH_W-1:0];
		sum = {a_q[`AWP_MANT_W-1], a_q} + {b_q[`AWP_MANT_W-1], b_q};
		sum_ovf = sum[`AWP_MANT_W] ^ sum[`AWP_MANT_W-1];
		ea_ext = {{EXT_W{ea_q[`AWP_EXP_W-1]}}, ea_q};
	end

	// ----------------------------------------------------------------------
	// FSM
	always_ff @(posedge got_fp or posedge _0_f) begin
		if (_0_f) begin
			state <= awp_pkg::IDLE;
			job_valid_q <= 1'b0;
		end else begin
			job_valid_q <= (state == awp_pkg::ISSUE);
			case (state)
				awp_pkg::IDLE:
					if (start)
						state <= (cmd.op == awp_pkg::AD) ? awp_pkg::ALIGN : awp_pkg::ISSUE;
				awp_pkg::ALIGN: state <= awp_pkg::ADD;
				awp_pkg::ADD: state <= awp_pkg::ISSUE;
				awp_pkg::ISSUE: state <= awp_pkg::WAIT;
				awp_pkg::WAIT:
					if (done)
						state <= awp_pkg::IDLE;
				default: state <= awp_pkg::IDLE;
			endcase
		end
	end

	// operands and job payload
	always_ff @(posedge got_fp) begin
		case (state)
			awp_pkg::IDLE:
				if (start) begin
					a_q <= cmd.mant_a;
					b_q <= cmd.mant_b;
					ea_q <= cmd.exp_a;
					eb_q <= cmd.exp_b;
					// NRF goes out as given
					res_mant_q <= cmd.mant_a;
					res_wexp_q <= {{EXT_W{cmd.exp_a[`AWP_EXP_W-1]}}, cmd.exp_a};
				end
			awp_pkg::ALIGN:
				if (a_smaller) begin
					a_q <= a_q >>> sh_amt;
					ea_q <= eb_q;
				end else begin
					b_q <= b_q >>> sh_amt;
				end
			awp_pkg::ADD:
				if (sum_ovf) begin
					res_mant_q <= sum[`AWP_MANT_W:1];
					res_wexp_q <= ea_ext + 1'b1;
				end else begin
					res_mant_q <= sum[`AWP_MANT_W-1:0];
					res_wexp_q <= ea_ext;
				end
			default: ;
		endcase
	end

	// payload holds still from ISSUE until the next start
	assign job = '{valid: job_valid_q, mant: res_mant_q, wexp: res_wexp_q};
	assign busy = (state != awp_pkg::IDLE);

	a_job_pulse: assert property (@(posedge got_fp) disable iff (_0_f)
		job.valid |=> !job.valid);
	a_start_idle: assert property (@(posedge got_fp) disable iff (_0_f)
		start |-> state == awp_pkg::IDLE);

endmodule

`default_nettype wire

/* awp_norm_stage.sv */
// one registered normalizing shift stage
// shifts left by SHIFT when the top SHIFT+1 bits are all sign
`timescale 1ns/1ns
`default_nettype none
`include "awp_macros.svh"

module awp_norm_stage #(
	parameter int SHIFT = 1
) (
	input  logic              got_fp,
	input  logic              _0_f,
	input  awp_pkg::awp_job_t job_in,
	output awp_pkg::awp_job_t job_out
);

	localparam int MSB = `AWP_MANT_W - 1;

	logic [SHIFT:0] top;
	logic do_shift;
	logic valid_q;
	awp_pkg::awp_mant_t mant_q;
	awp_pkg::awp_wexp_t wexp_q;

	// sign run test, zero is left alone
	assign top = job_in.mant[MSB -: SHIFT+1];
	assign do_shift = (job_in.mant != '0) && ((top == '0) || (top == '1));

	always_ff @(posedge got_fp or posedge _0_f) begin
		if (_0_f)
			valid_q <= 1'b0;
		else
			valid_q <= job_in.valid;
	end

	always_ff @(posedge got_fp) begin
		if (do_shift) begin
			mant_q <= job_in.mant << SHIFT;
			wexp_q <= job_in.wexp - awp_pkg::awp_wexp_t'(SHIFT);
		end else begin
			mant_q <= job_in.mant;
			wexp_q <= job_in.wexp;
		end
	end

	assign job_out = '{valid: valid_q, mant: mant_q, wexp: wexp_q};

	// exponent drops by at most this stage's amount
	// and no significant bit is pushed out over the sign
	a_wexp_step: assert property (@(posedge got_fp) disable iff (_0_f)
		job_in.valid |=> job_out.valid &&
		($signed(job_out.wexp) >= $signed($past(job_in.wexp)) - SHIFT) &&
		(job_out.mant[MSB] == $past(job_in.mant[MSB])));

endmodule

`default_nettype wire

/* awp_result.sv */
// result collector: exponent range check, flag forming, done pulse
`timescale 1ns/1ns
`default_nettype none
`include "awp_macros.svh"

module awp_result (
	input  logic              got_fp,
	input  logic              _0_f,
	input  awp_pkg::awp_job_t job,
	output awp_pkg::awp_res_t result,
	output logic              done
);

	localparam int EXP_MAX = (1 << (`AWP_EXP_W - 1)) - 1;
	localparam int EXP_MIN = -(1 << (`AWP_EXP_W - 1));

	awp_pkg::awp_res_t res_c;
	awp_pkg::awp_res_t res_q;
	logic done_q;

	// ----------------------------------------------------------------------
	// range check on the working exponent
	always_comb begin
		res_c.mant = job.mant;
		res_c.exp = job.wexp[`AWP_EXP_W-1:0];
		res_c.flags = '0;
		if (job.mant == '0) begin
			res_c.exp = '0;
			res_c.flags.zero = 1'b1;
		end else if ($signed(job.wexp) < EXP_MIN) begin
			// too small to represent, flush to zero
			res_c.mant = '0;
			res_c.exp = '0;
			res_c.flags.zero = 1'b1;
			res_c.flags.underflow = 1'b1;
		end else if ($signed(job.wexp) > EXP_MAX) begin
			// exponent keeps its low bits
			res_c.flags.overflow = 1'b1;
		end
	end

	always_ff @(posedge got_fp or posedge _0_f) begin
		if (_0_f)
			done_q <= 1'b0;
		else
			done_q <= job.valid;
	end

	always_ff @(posedge got_fp) begin
		res_q <= res_c;
	end

	assign result = res_q;
	assign done = done_q;

	// the chain must leave any nonzero mantissa normalized
	a_normalized: assert property (@(posedge got_fp) disable iff (_0_f)
		done && (result.mant != '0) && !result.flags.overflow |->
		result.mant[`AWP_MANT_W-1] != result.mant[`AWP_MANT_W-2]);

endmodule

`default_nettype wire

/* awp_top.sv */
// top level of the normalizing unit: register file, sequencer,
// chain of shift stages and result collector
`timescale 1ns/1ns
`default_nettype none
`include "awp_macros.svh"

module awp_top (
	input  logic                   got_fp,
	input  logic                   _0_f,
	input  logic [`AWP_ADDR_W-1:0] paddr,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic [`AWP_DATA_W-1:0] pwdata,
	output logic [`AWP_DATA_W-1:0] prdata,
	output logic                   pready,
	output logic                   pslverr,
	output logic                   irq
);

	awp_pkg::awp_cmd_t cmd;
	awp_pkg::awp_res_t result;
	logic start;
	logic busy;
	logic done;

	// chain[0] from the sequencer, chain[last] to the collector
	awp_pkg::awp_job_t chain [`AWP_NORM_STAGES+1];

	awp_apb_regs u_regs (
		.got_fp  (got_fp),
		._0_f    (_0_f),
		.paddr   (paddr),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.busy    (busy),
		.result  (result),
		.done    (done),
		.cmd     (cmd),
		.start   (start),
		.irq     (irq)
	);

	awp_seq u_seq (
		.got_fp (got_fp),
		._0_f   (_0_f),
		.cmd    (cmd),
		.start  (start),
		.done   (done),
		.job    (chain[0]),
		.busy   (busy)
	);

	// ----------------------------------------------------------------------
	// shift amounts 16, 8, 4, 2, 1
	for (genvar i = 0; i < `AWP_NORM_STAGES; i++) begin : g_stage
		awp_norm_stage #(
			.SHIFT (1 << (`AWP_NORM_STAGES - 1 - i))
		) u_stage (
			.got_fp  (got_fp),
			._0_f    (_0_f),
			.job_in  (chain[i]),
			.job_out (chain[i+1])
		);
	end

	awp_result u_result (
		.got_fp (got_fp),
		._0_f   (_0_f),
		.job    (chain[`AWP_NORM_STAGES]),
		.result (result),
		.done   (done)
	);

endmodule

`default_nettype wire

/* tb_awp_check.sv */
// checker: compares APB read data, pready, pslverr and irq with the
// values the testbench expects, and counts checks and errors
`timescale 1ns/1ns
`default_nettype none
`include "awp_macros.svh"

module tb_awp_check (
	input  logic                   got_fp,
	input  logic                   _0_f,
	input  logic [`AWP_ADDR_W-1:0] paddr,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic [`AWP_DATA_W-1:0] prdata,
	input  logic                   pready,
	input  logic                   pslverr,
	input  logic                   irq,
	input  int                     test_no,
	input  logic [31:0]            exp_data,
	input  logic [31:0]            exp_mask,
	input  logic                   exp_err,
	input  logic                   exp_irq,
	input  logic                   irq_chk,
	output int                     n_checks,
	output int                     n_errors
);

	int checks = 0;
	int errs = 0;

	function automatic string test_name(input int n);
		case (n)
			1: return "nrf_fixed";
			2: return "nrf_zero_underflow";
			3: return "ad_align_add";
			4: return "slave_error";
			5: return "irq_status";
			default: return "setup";
		endcase
	endfunction

	// ----------------------------------------------------------------------
	// sampled on the rising edge, inputs move on the falling one
	always @(posedge got_fp) begin
		if (!_0_f && psel && penable) begin
			checks++;
			if (pslverr !== exp_err) begin
				errs++;
				$display("[ERROR] %s: pslverr at 0x%02h expected %0b actual %0b",
					test_name(test_no), paddr, exp_err, pslverr);
			end
			// no wait states, every access completes at once
			checks++;
			if (pready !== 1'b1) begin
				errs++;
				$display("[ERROR] %s: pready at 0x%02h expected 1 actual %0b",
					test_name(test_no), paddr, pready);
			end
			// mask zero means an unchecked read
			if (!pwrite && exp_mask != '0) begin
				checks++;
				if ((prdata & exp_mask) !== (exp_data & exp_mask)) begin
					errs++;
					$display("[ERROR] %s: read 0x%02h expected 0x%08h actual 0x%08h",
						test_name(test_no), paddr, exp_data & exp_mask, prdata & exp_mask);
				end
			end
		end
		if (!_0_f && irq_chk) begin
			checks++;
			if (irq !== exp_irq) begin
				errs++;
				$display("[ERROR] %s: irq expected %0b actual %0b",
					test_name(test_no), exp_irq, irq);
			end
		end
	end

	assign n_checks = checks;
	assign n_errors = errs;

endmodule

`default_nettype wire

/* tb_awp.sv */
// testbench top for the normalizing unit: clock, reset, APB driver,
// LFSR stimulus, reference model and run timeout
`timescale 1ns/1ns
`default_nettype none
`include "awp_macros.svh"

module tb_awp;

	localparam int N_RAND = 20;
	// jobs of tests 1 to 5, fixed and random
	localparam int N_JOBS = 6 + 5 + 4 + N_RAND + 1 + 2;
	localparam int LIMIT = N_JOBS * 40 + 200;
	localparam longint MANT_HI = (longint'(1) <<< 31) - 1;
	localparam longint MANT_LO = -(longint'(1) <<< 31);
	localparam longint NORM_HI = longint'(1) <<< 30;

	logic got_fp;
	logic _0_f;
	logic [`AWP_ADDR_W-1:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [`AWP_DATA_W-1:0] pwdata;
	logic [`AWP_DATA_W-1:0] prdata;
	logic pready;
	logic pslverr;
	logic irq;

	int test_no;
	logic [31:0] exp_data;
	logic [31:0] exp_mask;
	logic exp_err;
	logic exp_irq;
	logic irq_chk;
	int n_checks;
	int n_errors;
	logic [31:0] lfsr;
	int cycles;

	awp_top u_awp_top (
		.got_fp  (got_fp),
		._0_f    (_0_f),
		.paddr   (paddr),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.irq     (irq)
	);

	tb_awp_check u_check (
		.got_fp   (got_fp),
		._0_f     (_0_f),
		.paddr    (paddr),
		.psel     (psel),
		.penable  (penable),
		.pwrite   (pwrite),
		.prdata   (prdata),
		.pready   (pready),
		.pslverr  (pslverr),
		.irq      (irq),
		.test_no  (test_no),
		.exp_data (exp_data),
		.exp_mask (exp_mask),
		.exp_err  (exp_err),
		.exp_irq  (exp_irq),
		.irq_chk  (irq_chk),
		.n_checks (n_checks),
		.n_errors (n_errors)
	);

	initial begin
		got_fp = 1'b0;
		forever #4 got_fp = ~got_fp;
	end

	// ----------------------------------------------------------------------
	// stimulus helpers
	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	// expected result from the align, add and normalize rules
	function automatic awp_pkg::awp_res_t ref_result(input logic op, input logic [31:0] ma,
		input logic [31:0] mb, input logic [7:0] ea, input logic [7:0] eb);
		awp_pkg::awp_res_t r;
		longint a;
		longint b;
		longint m;
		int e;
		int d;
		a = longint'($signed(ma));
		b = longint'($signed(mb));
		e = int'($signed(ea));
		m = a;
		if (op) begin
			d = int'($signed(eb)) - e;
			if (d > 0) begin
				a = a >>> ((d > 31) ? 31 : d);
				e = int'($signed(eb));
			end else begin
				b = b >>> ((-d > 31) ? 31 : -d);
			end
			m = a + b;
			if (m > MANT_HI || m < MANT_LO) begin
				m = m >>> 1;
				e = e + 1;
			end
		end
		// double until the value leaves the redundant sign band
		while (m != 0 && m >= -NORM_HI && m < NORM_HI) begin
			m = m * 2;
			e = e - 1;
		end
		r.mant = m[31:0];
		r.exp = e[7:0];
		r.flags = '0;
		if (m == 0) begin
			r.exp = '0;
			r.flags.zero = 1'b1;
		end else if (e < -128) begin
			r.mant = '0;
			r.exp = '0;
			r.flags.zero = 1'b1;
			r.flags.underflow = 1'b1;
		end else if (e > 127) begin
			r.flags.overflow = 1'b1;
		end
		return r;
	endfunction

	// STATUS bit map: busy 0, done 1, zero 4, underflow 5, overflow 6
	function automatic logic [31:0] status_word(input awp_pkg::awp_flags_t f,
		input logic done, input logic busy);
		logic [31:0] s;
		s = '0;
		s[0] = busy;
		s[1] = done;
		s[4] = f.zero;
		s[5] = f.underflow;
		s[6] = f.overflow;
		return s;
	endfunction

	// ----------------------------------------------------------------------
	// APB master, called on a falling edge
	task automatic apb_access(input logic wr, input logic [4:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata);
		paddr = addr;
		pwrite = wr;
		pwdata = wdata;
		psel = 1'b1;
		penable = 1'b0;
		@(negedge got_fp);
		penable = 1'b1;
		@(posedge got_fp);
		rdata = prdata;
		@(negedge got_fp);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic write_reg(input logic [4:0] addr, input logic [31:0] data, input logic err);
		logic [31:0] unused;
		exp_err = err;
		exp_mask = '0;
		apb_access(1'b1, addr, data, unused);
	endtask

	task automatic read_check(input logic [4:0] addr, input logic [31:0] data,
		input logic [31:0] mask, input logic err);
		logic [31:0] unused;
		exp_err = err;
		exp_data = data;
		exp_mask = mask;
		apb_access(1'b0, addr, '0, unused);
		exp_mask = '0;
	endtask

	task automatic read_raw(input logic [4:0] addr, output logic [31:0] data);
		exp_err = 1'b0;
		exp_mask = '0;
		apb_access(1'b0, addr, '0, data);
	endtask

	task automatic apply_reset();
		_0_f = 1'b1;
		repeat (3) @(negedge got_fp);
		_0_f = 1'b0;
	endtask

	// ----------------------------------------------------------------------
	// job level
	task automatic launch_job(input logic op, input logic [31:0] ma, input logic [31:0] mb,
		input logic [7:0] ea, input logic [7:0] eb, output awp_pkg::awp_res_t r);
		r = ref_result(op, ma, mb, ea, eb);
		write_reg(`AWP_REG_MANT_A, ma, 1'b0);
		write_reg(`AWP_REG_MANT_B, mb, 1'b0);
		write_reg(`AWP_REG_EXP_A, {24'd0, ea}, 1'b0);
		write_reg(`AWP_REG_EXP_B, {24'd0, eb}, 1'b0);
		write_reg(`AWP_REG_CMD, {31'd0, op}, 1'b0);
	endtask

	task automatic wait_done();
		logic [31:0] st;
		st = '0;
		while (!st[1])
			read_raw(`AWP_REG_STATUS, st);
	endtask

	task automatic check_result(input awp_pkg::awp_res_t r);
		read_check(`AWP_REG_RES_MANT, r.mant, '1, 1'b0);
		read_check(`AWP_REG_RES_EXP, {24'd0, r.exp}, '1, 1'b0);
		read_check(`AWP_REG_STATUS, status_word(r.flags, 1'b1, 1'b0), '1, 1'b0);
	endtask

	task automatic run_job(input logic op, input logic [31:0] ma, input logic [31:0] mb,
		input logic [7:0] ea, input logic [7:0] eb);
		awp_pkg::awp_res_t r;
		launch_job(op, ma, mb, ea, eb, r);
		wait_done();
		check_result(r);
	endtask

	// ----------------------------------------------------------------------
	initial begin
		awp_pkg::awp_res_t r;
		logic [31:0] ma;
		logic [31:0] mb;
		logic [31:0] ea;
		logic [31:0] eb;
		_0_f = 1'b1;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		test_no = 0;
		exp_data = '0;
		exp_mask = '0;
		exp_err = 1'b0;
		exp_irq = 1'b0;
		irq_chk = 1'b0;
		lfsr = 32'hf3df;
		apply_reset();

		test_no = 1;
		run_job(1'b0, 32'h40000000, '0, 8'd3, '0);
		run_job(1'b0, 32'h20000000, '0, 8'd0, '0);
		run_job(1'b0, 32'hc0000000, '0, 8'd5, '0);
		run_job(1'b0, 32'hffffffff, '0, 8'd0, '0);
		run_job(1'b0, 32'h00000001, '0, 8'd10, '0);
		run_job(1'b0, 32'h9abcdef0, '0, 8'hf9, '0);

		// zero, then exponents around -128
		test_no = 2;
		run_job(1'b0, 32'h00000000, '0, 8'd5, '0);
		run_job(1'b0, 32'h00000001, '0, 8'h9c, '0);
		run_job(1'b0, 32'h00010000, '0, 8'h92, '0);
		run_job(1'b0, 32'hffffffff, '0, 8'h9f, '0);
		run_job(1'b0, 32'h40000000, '0, 8'h80, '0);

		test_no = 3;
		run_job(1'b1, 32'h12345678, 32'h7fffffff, 8'd100, 8'h9c);
		run_job(1'b1, 32'h12345678, 32'h80000001, 8'h9c, 8'd100);
		run_job(1'b1, 32'h7fffffff, 32'h7fffffff, 8'd127, 8'd127);
		run_job(1'b1, 32'h80000000, 32'h80000000, 8'd126, 8'd126);
		for (int i = 0; i < N_RAND; i++) begin
			take_bits(32, ma);
			take_bits(32, mb);
			take_bits(8, ea);
			take_bits(8, eb);
			run_job(1'b1, ma, mb, ea[7:0], eb[7:0]);
		end

		// refused accesses leave the result alone
		test_no = 4;
		launch_job(1'b1, 32'h12345678, 32'h0badcafe, 8'd3, 8'd1, r);
		write_reg(`AWP_REG_CMD, 32'd0, 1'b1);
		wait_done();
		check_result(r);
		read_check(5'h1e, '0, '0, 1'b1);
		write_reg(5'h1d, 32'hffffffff, 1'b1);
		write_reg(`AWP_REG_RES_MANT, 32'h0, 1'b1);
		write_reg(`AWP_REG_RES_EXP, 32'h0, 1'b1);
		check_result(r);

		test_no = 5;
		launch_job(1'b0, 32'h00f00000, '0, 8'd2, '0, r);
		read_check(`AWP_REG_STATUS, 32'h1, 32'h1, 1'b0);
		while (!irq)
			@(negedge got_fp);
		exp_irq = 1'b1;
		irq_chk = 1'b1;
		repeat (3) @(negedge got_fp);
		check_result(r);
		exp_irq = 1'b0;
		@(negedge got_fp);
		irq_chk = 1'b0;
		// reset with irq pending
		launch_job(1'b0, 32'h00000003, '0, 8'd7, '0, r);
		while (!irq)
			@(negedge got_fp);
		apply_reset();
		irq_chk = 1'b1;
		read_check(`AWP_REG_STATUS, 32'h0, '1, 1'b0);
		irq_chk = 1'b0;

		$display("checks %0d errors %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	// run limit
	initial begin
		cycles = 0;
		while (cycles < LIMIT) begin
			@(posedge got_fp);
			cycles++;
		end
		$display("timeout: run did not finish within %0d cycles", LIMIT);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
+incdir+.
awp_pkg.sv
awp_apb_regs.sv
awp_seq.sv
awp_norm_stage.sv
awp_result.sv
awp_top.sv
tb_awp_check.sv
tb_awp.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator, pass only on TEST OK in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_awp \
	-Mdir obj_awp -o sim_awp
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_awp/sim_awp > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "TEST OK" sim.log; then
	exit 0
fi
exit 1
